//--- filelist.f
+incdir+.
obstacle_pkg.sv
throw_sequencer.sv
obstacle_motion.sv
pixel_overlay.sv
splitting_obstacle.sv
tb_splitting_obstacle.sv

//--- tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

////////////////////////////////////////////////////
// error counters and typed compares
////////////////////////////////////////////////////

int rgb_errors   = 0;
int point_errors = 0;
int bit_errors   = 0;
int other_errors = 0;

task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
    if (got !== exp) begin
        rgb_errors++;
        $display("ERROR %s: got %h expected %h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_point(input string name, input point_t got, input point_t exp);
    if (got !== exp) begin
        point_errors++;
        $display("ERROR %s: got (%h,%h) expected (%h,%h) at %0t",
                 name, got.x, got.y, exp.x, exp.y, $time);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        bit_errors++;
        $display("ERROR %s: got %h expected %h at %0t", name, got, exp, $time);
    end
endtask

// failures that are not a wrong value
task automatic report_other(input string what);
    other_errors++;
    $display("%0t: %s", $time, what);
endtask

function automatic int error_total();
    return rgb_errors + point_errors + bit_errors + other_errors;
endfunction

task automatic report_counts();
    $display("errors: rgb %0d, point %0d, done %0d, other %0d",
             rgb_errors, point_errors, bit_errors, other_errors);
endtask

`endif

//--- tb_splitting_obstacle.sv
`timescale 1ns/1ps

module tb_splitting_obstacle;
    import obstacle_pkg::*;

    localparam int AIM_CYCLES  = 40;
    localparam int MOVE_CYCLES = 4;
    localparam int INPUT_DELAY = 10;
    // aim, the whole drop to the bottom, and some slack
    localparam int THROW_CYCLES = AIM_CYCLES
        + int'(FIELD_BOTTOM - BIG_HALF - FIELD_TOP) * MOVE_CYCLES + 50;
    localparam int WATCHDOG_CYCLES = (AIM_CYCLES + 400 * MOVE_CYCLES + 200) * 6;
    localparam coord_t AIM_MOUSE_X = 12'd521;

    logic        clk = 1'b0;
    logic        rst;
    point_t      beam;
    logic        game_on;
    logic        menu_on;
    rgb_t        rgb_in;
    logic        play_selected;
    logic [3:0]  selected;
    logic        done_in;
    coord_t      mouse_xpos;
    rgb_t        rgb_out;
    point_t      hit;
    logic        done;
    logic [31:0] rng_state = 32'hd069;

    `include "tb_checks.svh"

    splitting_obstacle #(
        .aim_cycles  (AIM_CYCLES),
        .move_cycles (MOVE_CYCLES)
    ) i_splitting_obstacle (
        .clk           (clk),
        .rst           (rst),
        .beam          (beam),
        .game_on       (game_on),
        .menu_on       (menu_on),
        .rgb_in        (rgb_in),
        .play_selected (play_selected),
        .selected      (selected),
        .done_in       (done_in),
        .mouse_xpos    (mouse_xpos),
        .rgb_out       (rgb_out),
        .hit           (hit),
        .done          (done)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic point_t make_point(input coord_t x, input coord_t y);
        point_t p;
        p.x = x;
        p.y = y;
        return p;
    endfunction

    // outputs are sampled and inputs changed at this point
    task automatic step_cycle();
        @(posedge clk);
        #INPUT_DELAY;
    endtask

    // random background colour under the beam
    task automatic drive_beam(input point_t p, output rgb_t c);
        rng_state = xorshift32(rng_state);
        c = rng_state[11:0];
        beam = p;
        rgb_in = c;
    endtask

    task automatic probe_clear(input point_t p);
        rgb_t c;
        drive_beam(p, c);
        step_cycle();
        check_rgb("rgb_out", rgb_out, c);
        check_point("hit", hit, '0);
    endtask

    task automatic probe_painted(input point_t p);
        rgb_t c;
        drive_beam(p, c);
        step_cycle();
        check_rgb("rgb_out", rgb_out, OBSTACLE_RGB);
        check_point("hit", hit, p);
    endtask

    ////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////

    task automatic test_reset_idle();
        check_bit("done", done, 1'b0);
        check_rgb("rgb_out", rgb_out, '0);
        check_point("hit", hit, '0);
        repeat (4) probe_clear(make_point(START_X, FIELD_TOP));
    endtask

    task automatic test_start_gating();
        done_in = 1'b1;
        play_selected = 1'b1;
        selected = PLAY_ITEM - 4'd1;
        repeat (3) probe_clear(make_point(START_X, FIELD_TOP));
        // mouse set before the first aim cycle
        selected = PLAY_ITEM;
        mouse_xpos = AIM_MOUSE_X;
        probe_clear(make_point(START_X, FIELD_TOP));
        done_in = 1'b0;
        probe_painted(make_point(START_X, FIELD_TOP));
    endtask

    task automatic test_aim_follow();
        repeat (AIM_CYCLES - 2) step_cycle();
        // last aim cycle is still one step short of the mouse
        probe_clear(make_point(AIM_MOUSE_X + BIG_HALF, FIELD_TOP));
        probe_painted(make_point(AIM_MOUSE_X + BIG_HALF, FIELD_TOP));
        probe_clear(make_point(AIM_MOUSE_X + BIG_HALF + 12'd1, FIELD_TOP));
    endtask

    task automatic test_split_done();
        rgb_t   c;
        point_t bottom;
        int     cycles;
        logic   got_done;
        bottom = make_point(AIM_MOUSE_X, FIELD_BOTTOM - BIG_HALF);
        cycles = 0;
        got_done = 1'b0;
        while (!got_done && cycles < THROW_CYCLES) begin
            drive_beam(bottom, c);
            step_cycle();
            got_done = done;
            cycles++;
        end
        if (got_done) begin
            // big square sat on the bottom row in the last split cycle
            check_rgb("rgb_out", rgb_out, OBSTACLE_RGB);
            check_point("hit", hit, bottom);
        end else begin
            report_other("done never came after the split");
        end
        probe_clear(bottom);
        check_bit("done", done, 1'b0);
        repeat (20) begin
            step_cycle();
            check_bit("done", done, 1'b0);
        end
    endtask

    task automatic test_abort();
        point_t spot;
        spot = make_point(AIM_MOUSE_X, FIELD_TOP + 12'd13);
        done_in = 1'b1;
        probe_clear(spot);
        done_in = 1'b0;
        // well into the fall
        repeat (AIM_CYCLES + 20) step_cycle();
        probe_painted(spot);
        play_selected = 1'b0;
        probe_painted(spot);
        repeat (THROW_CYCLES) begin
            probe_clear(spot);
            check_bit("done", done, 1'b0);
        end
    endtask

    ////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////

    initial begin
        rst = 1'b1;
        beam = '0;
        game_on = 1'b1;
        menu_on = 1'b0;
        rgb_in = '0;
        play_selected = 1'b0;
        selected = '0;
        done_in = 1'b0;
        mouse_xpos = START_X;
        repeat (2) @(posedge clk);
        #INPUT_DELAY;
        rst = 1'b0;
        test_reset_idle();
        test_start_gating();
        test_aim_follow();
        test_split_done();
        test_abort();
        report_counts();
        if (error_total() == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        report_counts();
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- splitting_obstacle.sv
`timescale 1ns/1ps

module splitting_obstacle #(
    parameter int unsigned aim_cycles  = obstacle_pkg::AIM_CYCLES_DEFAULT,
    parameter int unsigned move_cycles = obstacle_pkg::MOVE_CYCLES_DEFAULT
) (
    input  logic                 clk,
    input  logic                 rst,
    input  obstacle_pkg::point_t beam,
    // game_on has no use here, kept for the game top level
    input  logic                 game_on,
    input  logic                 menu_on,
    input  obstacle_pkg::rgb_t   rgb_in,
    input  logic                 play_selected,
    input  logic [3:0]           selected,
    input  logic                 done_in,
    input  obstacle_pkg::coord_t mouse_xpos,
    output obstacle_pkg::rgb_t   rgb_out,
    output obstacle_pkg::point_t hit,
    output logic                 done
);
    import obstacle_pkg::*;

    phase_e   phase;
    squares_t squares;

    throw_sequencer #(.aim_cycles(aim_cycles)) i_throw_sequencer (
        .clk           (clk),
        .rst           (rst),
        .done_in       (done_in),
        .menu_on       (menu_on),
        .play_selected (play_selected),
        .selected      (selected),
        .squares       (squares),
        .phase         (phase),
        .done          (done)
    );

    obstacle_motion #(.move_cycles(move_cycles)) i_obstacle_motion (
        .clk        (clk),
        .rst        (rst),
        .phase      (phase),
        .mouse_xpos (mouse_xpos),
        .squares    (squares)
    );

    // one cycle behind the beam
    pixel_overlay i_pixel_overlay (
        .clk     (clk),
        .rst     (rst),
        .phase   (phase),
        .squares (squares),
        .beam    (beam),
        .rgb_in  (rgb_in),
        .rgb_out (rgb_out),
        .hit     (hit)
    );

endmodule

//--- pixel_overlay.sv
`timescale 1ns/1ps

module pixel_overlay (
    input  logic                   clk,
    input  logic                   rst,
    input  obstacle_pkg::phase_e   phase,
    input  obstacle_pkg::squares_t squares,
    input  obstacle_pkg::point_t   beam,
    input  obstacle_pkg::rgb_t     rgb_in,
    output obstacle_pkg::rgb_t     rgb_out,
    output obstacle_pkg::point_t   hit
);
    import obstacle_pkg::*;

    logic in_center;
    logic in_left;
    logic in_right;
    logic hit_now;

    // square of half width half around c, borders inclusive
    function automatic logic in_box(point_t p, point_t c, coord_t half);
        logic [12:0] px;
        logic [12:0] py;
        logic [12:0] cx;
        logic [12:0] cy;
        logic        ok_x;
        logic        ok_y;
        px   = {1'b0, p.x};
        py   = {1'b0, p.y};
        cx   = {1'b0, c.x};
        cy   = {1'b0, c.y};
        // one spare bit so the sums cannot wrap
        ok_x = (px + half >= cx) && (px <= cx + half);
        ok_y = (py + half >= cy) && (py <= cy + half);
        return ok_x && ok_y;
    endfunction

    ////////////////////////////////////////////////////
    // hit test
    ////////////////////////////////////////////////////

    assign in_center = in_box(beam, squares.center, BIG_HALF);
    assign in_left   = in_box(beam, squares.left, SMALL_HALF);
    assign in_right  = in_box(beam, squares.right, SMALL_HALF);

    // nothing drawn while idle
    assign hit_now = (phase != PH_IDLE) && (in_center || in_left || in_right);

    always_ff @(posedge clk) begin
        if (rst) begin
            rgb_out <= '0;
            hit     <= '0;
        end else if (hit_now) begin
            rgb_out <= OBSTACLE_RGB;
            hit     <= beam;
        end else begin
            rgb_out <= rgb_in;
            hit     <= '0;
        end
    end

endmodule

//--- obstacle_motion.sv
`timescale 1ns/1ps

module obstacle_motion #(
    parameter int unsigned move_cycles = obstacle_pkg::MOVE_CYCLES_DEFAULT
) (
    input  logic                   clk,
    input  logic                   rst,
    input  obstacle_pkg::phase_e   phase,
    input  obstacle_pkg::coord_t   mouse_xpos,
    output obstacle_pkg::squares_t squares
);
    import obstacle_pkg::*;

    squares_t             squares_nxt;
    phase_e               phase_q;
    logic [TIMER_W-1:0]   pace_cnt;
    logic [TIMER_W-1:0]   pace_cur;
    logic                 step;
    logic                 on_mouse;
    point_t               home;

    // launch point of all three squares
    assign home = '{x: START_X, y: FIELD_TOP};

    ////////////////////////////////////////////////////
    // pacing
    ////////////////////////////////////////////////////

    // counter starts over whenever the phase changes
    assign pace_cur = (phase != phase_q) ? '0 : pace_cnt;
    assign step     = (pace_cur == TIMER_W'(move_cycles - 1));
    assign on_mouse = (squares.center.x == mouse_xpos);

    ////////////////////////////////////////////////////
    // next positions
    ////////////////////////////////////////////////////

    always_comb begin
        squares_nxt = squares;
        case (phase)
            PH_IDLE: begin
                squares_nxt.center = home;
                squares_nxt.left   = home;
                squares_nxt.right  = home;
            end
            PH_AIM: begin
                // follow the mouse one pixel per step, x only
                if (step && !on_mouse) begin
                    if (squares.center.x < mouse_xpos) begin
                        squares_nxt.center.x = squares.center.x + 1'b1;
                        squares_nxt.left.x   = squares.left.x + 1'b1;
                        squares_nxt.right.x  = squares.right.x + 1'b1;
                    end else begin
                        squares_nxt.center.x = squares.center.x - 1'b1;
                        squares_nxt.left.x   = squares.left.x - 1'b1;
                        squares_nxt.right.x  = squares.right.x - 1'b1;
                    end
                end
            end
            PH_FALL: begin
                if (step) begin
                    squares_nxt.center.y = squares.center.y + 1'b1;
                    squares_nxt.left.y   = squares.left.y + 1'b1;
                    squares_nxt.right.y  = squares.right.y + 1'b1;
                end
            end
            PH_SPLIT: begin
                // small squares go off at 45 degrees
                if (step) begin
                    squares_nxt.center.y = squares.center.y + 1'b1;
                    squares_nxt.left.x   = squares.left.x - 1'b1;
                    squares_nxt.left.y   = squares.left.y + 1'b1;
                    squares_nxt.right.x  = squares.right.x + 1'b1;
                    squares_nxt.right.y  = squares.right.y + 1'b1;
                end
            end
            default: squares_nxt = squares;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase_q  <= PH_IDLE;
            pace_cnt <= '0;
            squares  <= '{center: home, left: home, right: home};
        end else begin
            phase_q <= phase;
            squares <= squares_nxt;
            // parked on the mouse, nothing to pace
            if ((phase == PH_IDLE) || step || ((phase == PH_AIM) && on_mouse)) begin
                pace_cnt <= '0;
            end else begin
                pace_cnt <= pace_cur + 1'b1;
            end
        end
    end

    // keeps steps off the phase change edges
    a_move_cycles_min: assert property (@(posedge clk) disable iff (rst)
        move_cycles >= 2);

endmodule

//--- throw_sequencer.sv
`timescale 1ns/1ps

module throw_sequencer #(
    parameter int unsigned aim_cycles = obstacle_pkg::AIM_CYCLES_DEFAULT
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   done_in,
    input  logic                   menu_on,
    input  logic                   play_selected,
    input  logic [3:0]             selected,
    input  obstacle_pkg::squares_t squares,
    output obstacle_pkg::phase_e   phase,
    output logic                   done
);
    import obstacle_pkg::*;

    phase_e               phase_nxt;
    logic                 done_nxt;
    logic [TIMER_W-1:0]   aim_cnt;
    logic                 start_req;
    logic                 abort_req;
    logic                 aim_end;
    logic                 at_split_depth;
    logic                 at_bottom;

    ////////////////////////////////////////////////////
    // phase conditions
    ////////////////////////////////////////////////////

    // menu must point at this obstacle
    assign start_req = done_in && play_selected && (selected == PLAY_ITEM);
    assign abort_req = menu_on || !play_selected;

    assign aim_end        = (aim_cnt == TIMER_W'(aim_cycles - 1));
    assign at_split_depth = (squares.center.y >= FIELD_TOP + SPLIT_DEPTH);
    // one check covers all three, they fall at the same rate
    assign at_bottom      = (squares.center.y >= FIELD_BOTTOM - BIG_HALF);

    always_comb begin
        phase_nxt = phase;
        done_nxt  = 1'b0;
        case (phase)
            PH_IDLE: begin
                if (start_req) begin
                    phase_nxt = PH_AIM;
                end
            end
            PH_AIM: begin
                if (abort_req) begin
                    phase_nxt = PH_IDLE;
                end else if (aim_end) begin
                    phase_nxt = PH_FALL;
                end
            end
            PH_FALL: begin
                if (abort_req) begin
                    phase_nxt = PH_IDLE;
                end else if (at_split_depth) begin
                    phase_nxt = PH_SPLIT;
                end
            end
            PH_SPLIT: begin
                if (abort_req) begin
                    phase_nxt = PH_IDLE;
                end else if (at_bottom) begin
                    phase_nxt = PH_IDLE;
                    done_nxt  = 1'b1;
                end
            end
            default: phase_nxt = PH_IDLE;
        endcase
    end

    ////////////////////////////////////////////////////
    // registers
    ////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            phase   <= PH_IDLE;
            done    <= 1'b0;
            aim_cnt <= '0;
        end else begin
            phase <= phase_nxt;
            done  <= done_nxt;
            // aim timer only runs while aiming
            if (phase != PH_AIM) begin
                aim_cnt <= '0;
            end else begin
                aim_cnt <= aim_cnt + 1'b1;
            end
        end
    end

    // done only as the split finishes
    a_done_after_split: assert property (@(posedge clk) disable iff (rst)
        done |-> ($past(phase) == PH_SPLIT) && (phase == PH_IDLE));

    // the fall phase is never skipped
    a_no_aim_to_split: assert property (@(posedge clk) disable iff (rst)
        (phase == PH_AIM) |=> (phase != PH_SPLIT));

endmodule

//--- obstacle_pkg.sv
package obstacle_pkg;

    ////////////////////////////////////////////////////
    // basic types
    ////////////////////////////////////////////////////

    typedef logic [11:0] coord_t;
    typedef logic [11:0] rgb_t;

    // beam position and damage pixel share this
    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    // big square plus the two small ones stacked on it
    typedef struct packed {
        point_t center;
        point_t left;
        point_t right;
    } squares_t;

    typedef enum logic [1:0] {
        PH_IDLE  = 2'd0,
        PH_AIM   = 2'd1,
        PH_FALL  = 2'd2,
        PH_SPLIT = 2'd3
    } phase_e;

    ////////////////////////////////////////////////////
    // timing and geometry
    ////////////////////////////////////////////////////

    localparam int TIMER_W = 26;
    // about one second at 65 MHz
    localparam int unsigned AIM_CYCLES_DEFAULT  = 65_000_000;
    localparam int unsigned MOVE_CYCLES_DEFAULT = 300_000;

    localparam coord_t BIG_HALF     = 12'd20;
    localparam coord_t SMALL_HALF   = 12'd15;
    localparam coord_t FIELD_TOP    = 12'd317;
    localparam coord_t FIELD_BOTTOM = 12'd617;
    localparam coord_t SPLIT_DEPTH  = 12'd100;
    localparam coord_t START_X      = 12'd511;

    localparam logic [3:0] PLAY_ITEM    = 4'd6;
    localparam rgb_t       OBSTACLE_RGB = 12'hfff;

endpackage
